//--- all.f
fetch_pkg.sv
icache_tags.sv
plru_tree.sv
fetch_ctrl.sv
ifetch_top.sv
tb_clock.sv
tb_ifetch.sv

//--- Makefile
TOP       ?= tb_ifetch
RTL_TOP   ?= ifetch_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?=
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
RTL_SRCS  ?= fetch_pkg.sv icache_tags.sv plru_tree.sv fetch_ctrl.sv ifetch_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q ">>> PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_ifetch.sv
`timescale 1ns/10ps

module tb_ifetch;
    import fetch_pkg::*;

    localparam int fill_none  = -1;
    localparam int fill_model = 8;

    typedef struct packed {
        logic       fence;
        addr_t      pc;
        logic       has_data;
        line_t      data;
        logic [1:0] trap;
        way_vec_t   hit;
        logic [2:0] size;
        addr_t      addr;
        int         fill;
        int         hold;
    } row_t;

    logic     clk;
    logic     rst;
    logic     pc_valid;
    addr_t    pc;
    logic     fence_i;
    logic     pc_ready;
    logic     out_valid;
    logic     out_ready;
    trap_t    out_trap;
    line_t    out_data;
    way_vec_t hit_way;
    logic     arvalid;
    logic     arready;
    addr_t    araddr;
    logic [2:0] arsize;
    logic     rvalid;
    logic     rready;
    line_t    rdata;
    logic     refill_we;
    way_t     refill_way;
    index_t   refill_index;
    line_t    refill_data;

    row_t        rows[$];
    string       names[$];
    logic [6:0]  plru_model [num_sets];
    logic [31:0] rng_state;
    int          errors;
    int          cycles;
    int          cycle_limit;
    logic        running;

    tb_clock clock_i (
        .clk (clk),
        .rst (rst)
    );

    ifetch_top dut_i (.*);

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // 0 goes to the lower side, 1 to the upper side
    function automatic int choose_victim(input logic [6:0] t);
        int half;
        int pair;
        half = t[0] ? 1 : 0;
        pair = half * 2 + (t[1 + half] ? 1 : 0);
        return pair * 2 + (t[3 + pair] ? 1 : 0);
    endfunction

    task automatic touch_way(input int set, input int w);
        plru_model[set][0]         = (w < 4);
        plru_model[set][1 + w / 4] = ((w / 2) % 2 == 0);
        plru_model[set][3 + w / 2] = (w % 2 == 0);
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Fail %s expected %0h actual %0h", what, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "mismatch in %s", what);
        end
    endtask

    task automatic add_row(input string name, input logic fence, input addr_t pc_v,
                           input logic has_data, input line_t data, input logic [1:0] trap,
                           input way_vec_t hit, input logic [2:0] size, input addr_t addr,
                           input int fill, input int hold);
        row_t row;
        row = '{fence, pc_v, has_data, data, trap, hit, size, addr, fill, hold};
        rows.push_back(row);
        names.push_back(name);
    endtask

    task automatic build_table();
        // misaligned pcs trap without a bus access
        add_row("misalign_c", 0, 32'h8000_0102, 0, '0, trap_misalign, 8'h00, 0, '0, fill_none, 0);
        add_row("misalign_u", 0, 32'h0000_0041, 0, '0, trap_misalign, 8'h00, 0, '0, fill_none, 0);
        // uncached word fetches
        add_row("uncached_a", 0, 32'h0000_1234, 1, 64'h0000_0000_1300_0093, trap_none, 8'h00,
                size_word, 32'h0000_1234, fill_none, 0);
        add_row("uncached_b", 0, 32'h0000_2004, 0, '0, trap_none, 8'h00,
                size_word, 32'h0000_2004, fill_none, 0);
        // miss then hit in set 3
        add_row("miss_set3", 0, 32'h8000_041C, 0, '0, trap_none, 8'h01,
                size_dword, 32'h8000_0418, 0, 0);
        add_row("hit_set3", 0, 32'h8000_041C, 0, '0, trap_none, 8'h01, 0, '0, fill_none, 0);
        // fill all eight ways of set 5
        add_row("set5_w0", 0, 32'h8000_0228, 0, '0, trap_none, 8'h01, size_dword, 32'h8000_0228, 0, 0);
        add_row("set5_w1", 0, 32'h8000_0428, 0, '0, trap_none, 8'h02, size_dword, 32'h8000_0428, 1, 0);
        add_row("set5_w2", 0, 32'h8000_0628, 0, '0, trap_none, 8'h04, size_dword, 32'h8000_0628, 2, 0);
        add_row("set5_w3", 0, 32'h8000_0828, 0, '0, trap_none, 8'h08, size_dword, 32'h8000_0828, 3, 0);
        add_row("set5_w4", 0, 32'h8000_0A28, 0, '0, trap_none, 8'h10, size_dword, 32'h8000_0A28, 4, 0);
        add_row("set5_w5", 0, 32'h8000_0C28, 0, '0, trap_none, 8'h20, size_dword, 32'h8000_0C28, 5, 0);
        add_row("set5_w6", 0, 32'h8000_0E28, 0, '0, trap_none, 8'h40, size_dword, 32'h8000_0E28, 6, 0);
        add_row("set5_w7", 0, 32'h8000_1028, 0, '0, trap_none, 8'h80, size_dword, 32'h8000_1028, 7, 0);
        add_row("set5_hit0", 0, 32'h8000_0228, 0, '0, trap_none, 8'h01, 0, '0, fill_none, 0);
        add_row("set5_hit6", 0, 32'h8000_0E28, 0, '0, trap_none, 8'h40, 0, '0, fill_none, 0);
        // ninth tag evicts the tree victim
        add_row("set5_evict", 0, 32'h8000_1228, 0, '0, trap_none, 8'h00,
                size_dword, 32'h8000_1228, fill_model, 0);
        add_row("fence", 1, '0, 0, '0, trap_none, 8'h00, 0, '0, fill_none, 0);
        add_row("fence_miss", 0, 32'h8000_041C, 0, '0, trap_none, 8'h01,
                size_dword, 32'h8000_0418, 0, 0);
        // consumer stalls an uncached beat
        add_row("uncached_hold", 0, 32'h0000_3000, 1, 64'hDEAD_BEEF_0040_0513, trap_none, 8'h00,
                size_word, 32'h0000_3000, fill_none, 5);
        add_row("after_hold", 0, 32'h8000_0800, 0, '0, trap_none, 8'h01,
                size_dword, 32'h8000_0800, 0, 0);
    endtask

    task automatic run_row(input int r);
        row_t     row;
        string    name;
        line_t    beat;
        way_vec_t exp_hit;
        int       exp_fill;
        int       idx;
        int       ar_wait;
        int       r_wait;
        int       ar_cnt;
        int       r_cnt;
        int       held;
        int       ar_xfers;
        int       r_xfers;
        int       fills;
        logic     stalled;
        logic     done;
        row      = rows[r];
        name     = names[r];
        idx      = int'(row.pc[offset_w +: index_w]);
        beat     = row.has_data ? row.data : {next_random(), next_random()};
        ar_wait  = int'(next_random() % 4);
        r_wait   = int'(next_random() % 4);
        exp_fill = (row.fill == fill_model) ? choose_victim(plru_model[idx]) : row.fill;
        exp_hit  = (row.fill == fill_model) ? way_vec_t'(1 << exp_fill) : row.hit;
        ar_cnt   = 0;
        r_cnt    = 0;
        held     = 0;
        ar_xfers = 0;
        r_xfers  = 0;
        fills    = 0;
        stalled  = 1'b0;
        done     = 1'b0;
        while (!done) begin
            @(posedge clk);
            #1;
            pc_valid  = !row.fence;
            pc        = row.pc;
            fence_i   = row.fence;
            out_ready = held >= row.hold;
            // slave side of the read channel
            if (arvalid) begin
                arready = ar_cnt >= ar_wait;
                ar_cnt++;
            end else begin
                arready = 1'b0;
            end
            if (rready) begin
                rvalid = r_cnt >= r_wait;
                r_cnt++;
            end else begin
                rvalid = 1'b0;
            end
            rdata = beat;
            #2;
            if (arvalid) begin
                if (row.size == 3'd0) begin
                    check_value({name, " arvalid"}, 0, 1);
                end
                check_value({name, " araddr"}, row.addr, araddr);
                check_value({name, " arsize"}, row.size, arsize);
                if (arready) begin
                    ar_xfers++;
                end
            end
            if (rready && rvalid) begin
                r_xfers++;
            end
            if (refill_we) begin
                fills++;
                check_value({name, " refill_way"}, exp_fill, refill_way);
                check_value({name, " refill_index"}, idx, refill_index);
                check_value({name, " refill_data"}, beat, refill_data);
            end
            if (row.fence) begin
                check_value({name, " out_valid"}, 0, out_valid);
            end
            // a stalled item stays on the output
            if (stalled) begin
                check_value({name, " out_valid in stall"}, 1, out_valid);
            end
            if (out_valid) begin
                check_value({name, " out_trap"}, row.trap, out_trap);
                check_value({name, " hit_way"}, exp_hit, hit_way);
                if (row.size != 3'd0) begin
                    check_value({name, " out_data"}, beat, out_data);
                end
                if (!out_ready) begin
                    held++;
                end
            end
            stalled = out_valid && !out_ready;
            done    = pc_ready;
        end
        check_value({name, " ar transfers"}, row.size != 3'd0, ar_xfers);
        check_value({name, " r transfers"}, row.size != 3'd0, r_xfers);
        check_value({name, " refills"}, exp_fill >= 0, fills);
        // accepted hit moves the tree
        for (int w = 0; w < num_ways; w++) begin
            if (exp_hit[w]) begin
                touch_way(idx, w);
            end
        end
    endtask

    always @(posedge clk) begin
        if (running) begin
            cycles = cycles + 1;
            if (cycles > cycle_limit) begin
                $display("timeout after %0d cycles, the fetch stage stopped answering", cycles);
                $display(">>> FAIL");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        pc_valid    = 1'b0;
        pc          = '0;
        fence_i     = 1'b0;
        out_ready   = 1'b1;
        arready     = 1'b0;
        rvalid      = 1'b0;
        rdata       = '0;
        rng_state   = 32'd34;
        errors      = 0;
        cycles      = 0;
        running     = 1'b0;
        for (int s = 0; s < num_sets; s++) begin
            plru_model[s] = '0;
        end
        build_table();
        cycle_limit = rows.size() * 20;
        wait (rst == 1'b0);
        running = 1'b1;
        for (int r = 0; r < rows.size(); r++) begin
            run_row(r);
        end
        @(posedge clk);
        #1;
        pc_valid = 1'b0;
        fence_i  = 1'b0;
        arready  = 1'b0;
        rvalid   = 1'b0;
        if (errors == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "%0d checks failed", errors);
        end
    end

endmodule

//--- tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic rst
);
    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

//--- ifetch_top.sv
`timescale 1ns/10ps

module ifetch_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                pc_valid,
    input  fetch_pkg::addr_t    pc,
    input  logic                fence_i,
    output logic                pc_ready,
    output logic                out_valid,
    input  logic                out_ready,
    output fetch_pkg::trap_t    out_trap,
    output fetch_pkg::line_t    out_data,
    output fetch_pkg::way_vec_t hit_way,
    output logic                arvalid,
    input  logic                arready,
    output fetch_pkg::addr_t    araddr,
    output logic [2:0]          arsize,
    input  logic                rvalid,
    output logic                rready,
    input  fetch_pkg::line_t    rdata,
    output logic                refill_we,
    output fetch_pkg::way_t     refill_way,
    output fetch_pkg::index_t   refill_index,
    output fetch_pkg::line_t    refill_data
);
    import fetch_pkg::*;

    way_vec_t hit_vec;
    logic     free_found;
    way_t     free_way;
    way_t     victim_way;
    logic     install;
    way_t     install_way;
    logic     touch;

    icache_tags tags_i (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .install     (install),
        .install_way (install_way),
        .fence_i     (fence_i),
        .hit_vec     (hit_vec),
        .free_found  (free_found),
        .free_way    (free_way)
    );

    plru_tree plru_i (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .touch      (touch),
        .hit_vec    (hit_vec),
        .victim_way (victim_way)
    );

    fetch_ctrl ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .pc_valid     (pc_valid),
        .pc           (pc),
        .fence_i      (fence_i),
        .pc_ready     (pc_ready),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_trap     (out_trap),
        .out_data     (out_data),
        .hit_way      (hit_way),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .arsize       (arsize),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .hit_vec      (hit_vec),
        .free_found   (free_found),
        .free_way     (free_way),
        .victim_way   (victim_way),
        .install      (install),
        .install_way  (install_way),
        .touch        (touch),
        .refill_we    (refill_we),
        .refill_way   (refill_way),
        .refill_index (refill_index),
        .refill_data  (refill_data)
    );

endmodule

//--- fetch_ctrl.sv
`timescale 1ns/10ps

module fetch_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                pc_valid,
    input  fetch_pkg::addr_t    pc,
    input  logic                fence_i,
    output logic                pc_ready,
    output logic                out_valid,
    input  logic                out_ready,
    output fetch_pkg::trap_t    out_trap,
    output fetch_pkg::line_t    out_data,
    output fetch_pkg::way_vec_t hit_way,
    output logic                arvalid,
    input  logic                arready,
    output fetch_pkg::addr_t    araddr,
    output logic [2:0]          arsize,
    input  logic                rvalid,
    output logic                rready,
    input  fetch_pkg::line_t    rdata,
    input  fetch_pkg::way_vec_t hit_vec,
    input  logic                free_found,
    input  fetch_pkg::way_t     free_way,
    input  fetch_pkg::way_t     victim_way,
    output logic                install,
    output fetch_pkg::way_t     install_way,
    output logic                touch,
    output logic                refill_we,
    output fetch_pkg::way_t     refill_way,
    output fetch_pkg::index_t   refill_index,
    output fetch_pkg::line_t    refill_data
);
    import fetch_pkg::*;

    fetch_state_t state_q;
    fetch_state_t state_d;
    line_t        data_q;
    logic         misalign;
    logic         uncached;
    logic         hit;
    logic         fence_take;

    // no compressed instructions, so bits 1:0 must be zero
    assign misalign = pc[1:0] != 2'b00;
    // upper half of the address space is cached
    assign uncached = ~pc[addr_w-1];
    assign hit      = |hit_vec;

    assign araddr  = uncached ? pc : {pc[addr_w-1:offset_w], {offset_w{1'b0}}};
    assign arsize  = uncached ? size_word : size_dword;
    assign arvalid = state_q == fs_addr;
    assign rready  = state_q == fs_data;

    // refill goes to a free way first
    assign refill_we    = state_q == fs_fill;
    assign refill_way   = free_found ? free_way : victim_way;
    assign refill_index = pc[offset_w +: index_w];
    assign refill_data  = data_q;
    assign install      = refill_we;
    assign install_way  = refill_way;

    assign pc_ready = (out_valid && out_ready) || fence_take;

    always_comb begin
        state_d    = state_q;
        out_valid  = 1'b0;
        out_trap   = trap_none;
        out_data   = data_q;
        hit_way    = '0;
        touch      = 1'b0;
        fence_take = 1'b0;
        case (state_q)
            fs_idle: begin
                if (fence_i) begin
                    fence_take = 1'b1;
                end else if (pc_valid) begin
                    if (misalign) begin
                        out_valid = 1'b1;
                        out_trap  = trap_misalign;
                    end else if (!uncached && hit) begin
                        out_valid = 1'b1;
                        hit_way   = hit_vec;
                        touch     = out_ready;
                    end else begin
                        state_d = fs_addr;
                    end
                end
            end
            fs_addr: begin
                if (arready) begin
                    state_d = fs_data;
                end
            end
            fs_data: begin
                if (rvalid) begin
                    if (uncached) begin
                        out_valid = 1'b1;
                        out_data  = rdata;
                        state_d   = out_ready ? fs_idle : fs_hold;
                    end else begin
                        state_d = fs_fill;
                    end
                end
            end
            fs_fill: begin
                state_d = fs_idle;
            end
            fs_hold: begin
                out_valid = 1'b1;
                if (out_ready) begin
                    state_d = fs_idle;
                end
            end
            default: begin
                state_d = fs_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= fs_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // bus beat, kept for fill and hold
    always_ff @(posedge clk) begin
        if (rvalid && rready) begin
            data_q <= rdata;
        end
    end

endmodule

//--- plru_tree.sv
`timescale 1ns/10ps

module plru_tree (
    input  logic                clk,
    input  logic                rst,
    input  fetch_pkg::addr_t    pc,
    input  logic                touch,
    input  fetch_pkg::way_vec_t hit_vec,
    output fetch_pkg::way_t     victim_way
);
    import fetch_pkg::*;

    logic [plru_w-1:0] tree_q [num_sets];
    logic [plru_w-1:0] tree;
    index_t            index;
    way_t              hit_idx;
    logic [2:0]        upd_half;
    logic [2:0]        upd_pair;
    logic              v_half;
    logic              v_pair;

    assign index = pc[offset_w +: index_w];
    assign tree  = tree_q[index];

    // one-hot hit to way number
    always_comb begin
        hit_idx = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_vec[w]) begin
                hit_idx = way_t'(w);
            end
        end
    end

    // bits on the path of the touched way
    assign upd_half = 3'd1 + {2'b00, hit_idx[2]};
    assign upd_pair = 3'd3 + {1'b0, hit_idx[2:1]};

    // 0 goes low, 1 goes high
    always_comb begin
        v_half     = tree[0];
        v_pair     = v_half ? tree[2] : tree[1];
        victim_way = {v_half, v_pair, tree[{1'b0, v_half, v_pair} + 3'd3]};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch) begin
            // point every level away from the touched way
            tree_q[index][0]        <= ~hit_idx[2];
            tree_q[index][upd_half] <= ~hit_idx[1];
            tree_q[index][upd_pair] <= ~hit_idx[0];
        end
    end

endmodule

//--- icache_tags.sv
`timescale 1ns/10ps

module icache_tags (
    input  logic                clk,
    input  logic                rst,
    input  fetch_pkg::addr_t    pc,
    input  logic                install,
    input  fetch_pkg::way_t     install_way,
    input  logic                fence_i,
    output fetch_pkg::way_vec_t hit_vec,
    output logic                free_found,
    output fetch_pkg::way_t     free_way
);
    import fetch_pkg::*;

    way_vec_t valid_q [num_sets];
    tag_t     tag_q   [num_sets][num_ways];
    index_t   index;
    tag_t     tag;

    assign index = pc[offset_w +: index_w];
    assign tag   = pc[addr_w-1 -: tag_w];

    // compare all ways of the set
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit_vec[w] = valid_q[index][w] && (tag_q[index][w] == tag);
        end
    end

    // lowest invalid way wins, so scan downwards
    always_comb begin
        free_found = 1'b0;
        free_way   = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid_q[index][w]) begin
                free_found = 1'b1;
                free_way   = way_t'(w);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s] <= '0;
            end
        end else begin
            if (fence_i) begin
                for (int s = 0; s < num_sets; s++) begin
                    valid_q[s] <= '0;
                end
            end
            // a fill in the same cycle stays valid
            if (install) begin
                valid_q[index][install_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (install) begin
            tag_q[index][install_way] <= tag;
        end
    end

endmodule

//--- fetch_pkg.sv
package fetch_pkg;

    // address and cache geometry
    localparam int addr_w   = 32;
    localparam int num_ways = 8;
    localparam int way_w    = 3;
    localparam int num_sets = 64;
    localparam int index_w  = 6;
    localparam int offset_w = 3;
    localparam int tag_w    = 23;
    localparam int line_w   = 64;
    localparam int plru_w   = 7;

    // arsize codes
    localparam logic [2:0] size_word  = 3'd2;
    localparam logic [2:0] size_dword = 3'd3;

    typedef logic [addr_w-1:0]   addr_t;
    typedef logic [tag_w-1:0]    tag_t;
    typedef logic [index_w-1:0]  index_t;
    typedef logic [way_w-1:0]    way_t;
    typedef logic [num_ways-1:0] way_vec_t;
    typedef logic [line_w-1:0]   line_t;

    typedef enum logic [1:0] {
        trap_none     = 2'd0,
        trap_misalign = 2'd1
    } trap_t;

    typedef enum logic [2:0] {
        fs_idle,
        fs_addr,
        fs_data,
        fs_fill,
        fs_hold
    } fetch_state_t;

endpackage
